// File: Bender.yml
package:
  name: scoreboard_top

sources:
  - common/scb_sid_pkg.sv
  - common/scb_unit_pkg.sv
  - issue/scb_issue.sv
  - source/scb_slot_table.sv
  - source/scb_raw_check.sv
  - source/scb_redirect_flush.sv
  - source/scoreboard_top.sv
  - target: test
    files:
      - bench/scoreboard_tb.sv

// File: bench/scoreboard_tb.sv
`timescale 1ns/1ps

module scoreboard_tb;

    typedef struct packed {
        logic                     d0_stall;
        logic                     d1_stall;
        scb_sid_pkg::sid_t        d0_sid;
        scb_sid_pkg::sid_t        d1_sid;
        scb_unit_pkg::slot_mask_t d0_slot;
        scb_unit_pkg::slot_mask_t d1_slot;
        logic                     op0_stall;
        logic                     op1_stall;
        logic                     d0_flush;
        logic                     d1_flush;
        logic                     op0_flush;
        logic                     op1_flush;
        scb_unit_pkg::slot_mask_t kill;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic dec0_vld_i, dec1_vld_i, op0_vld_i, op1_vld_i;
    logic wb0_vld_i, wb1_vld_i, wb_redirect_i;
    scb_unit_pkg::exe_unit_e  dec0_unit_i, dec1_unit_i;
    scb_sid_pkg::reg_addr_t   dec0_rd_i, dec0_rs1_i, dec0_rs2_i;
    scb_sid_pkg::reg_addr_t   dec1_rd_i, dec1_rs1_i, dec1_rs2_i;
    scb_sid_pkg::reg_addr_t   op0_rd_i, op0_rs1_i, op0_rs2_i;
    scb_sid_pkg::reg_addr_t   op1_rd_i, op1_rs1_i, op1_rs2_i;
    scb_sid_pkg::sid_t        op0_sid_i, op1_sid_i, wb0_sid_i, wb1_sid_i, wb_redirect_sid_i;
    logic dec0_stall_o, dec1_stall_o, dec0_flush_o, dec1_flush_o;
    logic op0_stall_o, op1_stall_o, op0_flush_o, op1_flush_o;
    scb_sid_pkg::sid_t        dec0_sid_o, dec1_sid_o;
    scb_unit_pkg::slot_mask_t dec0_slot_o, dec1_slot_o;

    // shadow copy of the slot table and sid counter
    scb_unit_pkg::slot_mask_t sh_busy;
    scb_sid_pkg::reg_addr_t   sh_rd [scb_unit_pkg::NUM_SLOTS];
    scb_sid_pkg::sid_t        sh_sid [scb_unit_pkg::NUM_SLOTS];
    scb_sid_pkg::sid_t        sh_cnt;
    exp_t                     ex = '0;
    int                       errors = 0;

    scoreboard_top dut0 (.*);

    always #5 clk = ~clk;

    // a is younger when a - b lands in the lower half of the sid ring
    function automatic logic younger(input scb_sid_pkg::sid_t a, input scb_sid_pkg::sid_t b);
        scb_sid_pkg::sid_t d;
        d = a - b;
        return (d != 0) && !d[scb_sid_pkg::SID_IDX_WIDTH];
    endfunction

    function automatic scb_unit_pkg::slot_mask_t choose(input scb_unit_pkg::exe_unit_e u,
                                                        input scb_unit_pkg::slot_mask_t busy);
        scb_unit_pkg::slot_mask_t m;
        m = '0;
        if (u == scb_unit_pkg::EXE_ALU && !busy[0]) m[0] = 1'b1;
        else if (u == scb_unit_pkg::EXE_ALU && !busy[1]) m[1] = 1'b1;
        else if (u == scb_unit_pkg::EXE_BEU) m[2] = !busy[2];
        else if (u == scb_unit_pkg::EXE_LSU) m[3] = !busy[3];
        return m;
    endfunction

    function automatic exp_t predict();
        exp_t r;
        scb_unit_pkg::slot_mask_t p0, p1;
        logic w0, w1, h0, h1, ok0, ok1;
        r = '0;
        w0 = 1'b0;
        w1 = 1'b0;
        h0 = 1'b0;
        h1 = 1'b0;
        for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
            if (sh_busy[i]) begin
                w0 |= sh_rd[i] == dec0_rd_i;
                w1 |= sh_rd[i] == dec1_rd_i;
                h0 |= (sh_rd[i] == op0_rs1_i || sh_rd[i] == op0_rs2_i) &&
                      younger(op0_sid_i, sh_sid[i]);
                h1 |= (sh_rd[i] == op1_rs1_i || sh_rd[i] == op1_rs2_i) &&
                      younger(op1_sid_i, sh_sid[i]);
                r.kill[i] = wb_redirect_i && younger(sh_sid[i], wb_redirect_sid_i);
            end
        end
        p0 = choose(dec0_unit_i, sh_busy);
        ok0 = dec0_vld_i && (p0 != '0) && !w0;
        r.d0_slot = ok0 ? p0 : '0;
        p1 = choose(dec1_unit_i, sh_busy | r.d0_slot);
        ok1 = dec1_vld_i && (p1 != '0) && !w1 && !(dec0_vld_i && dec0_rd_i == dec1_rd_i) &&
              !(dec0_vld_i && !ok0);
        r.d1_slot = ok1 ? p1 : '0;
        r.d0_stall = dec0_vld_i && !ok0;
        r.d1_stall = dec1_vld_i && !ok1;
        r.d0_sid = sh_cnt;
        r.d1_sid = sh_cnt + 1;
        h0 |= op1_vld_i && (op1_rd_i == op0_rs1_i || op1_rd_i == op0_rs2_i) &&
              younger(op0_sid_i, op1_sid_i);
        h1 |= op0_vld_i && (op0_rd_i == op1_rs1_i || op0_rd_i == op1_rs2_i) &&
              younger(op1_sid_i, op0_sid_i);
        r.op0_stall = op0_vld_i && h0;
        r.op1_stall = op1_vld_i && h1;
        r.d0_flush  = wb_redirect_i && dec0_vld_i && younger(r.d0_sid, wb_redirect_sid_i);
        r.d1_flush  = wb_redirect_i && dec1_vld_i && younger(r.d1_sid, wb_redirect_sid_i);
        r.op0_flush = wb_redirect_i && op0_vld_i && younger(op0_sid_i, wb_redirect_sid_i);
        r.op1_flush = wb_redirect_i && op1_vld_i && younger(op1_sid_i, wb_redirect_sid_i);
        return r;
    endfunction

    task automatic check_flag(input string name, input logic e, input logic a);
        if (a !== e) begin
            errors++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, e, a);
        end
    endtask

    task automatic check_sid(input string name, input scb_sid_pkg::sid_t e,
                             input scb_sid_pkg::sid_t a);
        if (a !== e) begin
            errors++;
            $display("FAIL %0t %s expected %h actual %h", $time, name, e, a);
        end
    endtask

    task automatic check_slot(input string name, input scb_unit_pkg::slot_mask_t e,
                              input scb_unit_pkg::slot_mask_t a);
        if (a !== e) begin
            errors++;
            $display("FAIL %0t %s expected %b actual %b", $time, name, e, a);
        end
    endtask

    // outputs are settled halfway through the cycle
    always @(negedge clk) begin
        if (rst_n) begin
            ex = predict();
            check_flag("dec0_stall_o", ex.d0_stall, dec0_stall_o);
            check_flag("dec1_stall_o", ex.d1_stall, dec1_stall_o);
            check_sid("dec0_sid_o", ex.d0_sid, dec0_sid_o);
            check_sid("dec1_sid_o", ex.d1_sid, dec1_sid_o);
            check_slot("dec0_slot_o", ex.d0_slot, dec0_slot_o);
            check_slot("dec1_slot_o", ex.d1_slot, dec1_slot_o);
            check_flag("op0_stall_o", ex.op0_stall, op0_stall_o);
            check_flag("op1_stall_o", ex.op1_stall, op1_stall_o);
            check_flag("dec0_flush_o", ex.d0_flush, dec0_flush_o);
            check_flag("dec1_flush_o", ex.d1_flush, dec1_flush_o);
            check_flag("op0_flush_o", ex.op0_flush, op0_flush_o);
            check_flag("op1_flush_o", ex.op1_flush, op1_flush_o);
        end
    end

    // rising edge, then shadow update with kill before write before release
    task automatic tick();
        @(posedge clk);
        if (!rst_n) begin
            sh_busy = '0;
            sh_cnt = '0;
            for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
                sh_rd[i] = '0;
                sh_sid[i] = '0;
            end
        end else begin
            for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
                if (ex.kill[i]) begin
                    sh_busy[i] = 1'b0;
                end else if (ex.d0_slot[i]) begin
                    sh_busy[i] = 1'b1;
                    sh_rd[i] = dec0_rd_i;
                    sh_sid[i] = sh_cnt;
                end else if (ex.d1_slot[i]) begin
                    sh_busy[i] = 1'b1;
                    sh_rd[i] = dec1_rd_i;
                    sh_sid[i] = sh_cnt + 1;
                end else if ((wb0_vld_i && wb0_sid_i == sh_sid[i]) ||
                             (wb1_vld_i && wb1_sid_i == sh_sid[i])) begin
                    sh_busy[i] = 1'b0;
                end
            end
            sh_cnt = sh_cnt + scb_sid_pkg::sid_t'(ex.d0_slot != '0) +
                     scb_sid_pkg::sid_t'(ex.d1_slot != '0);
        end
    endtask

    task automatic idle();
        {dec0_vld_i, dec1_vld_i, op0_vld_i, op1_vld_i} <= '0;
        {wb0_vld_i, wb1_vld_i, wb_redirect_i} <= '0;
        {dec0_rd_i, dec0_rs1_i, dec0_rs2_i, dec1_rd_i, dec1_rs1_i, dec1_rs2_i} <= '0;
        {op0_rd_i, op0_rs1_i, op0_rs2_i, op1_rd_i, op1_rs1_i, op1_rs2_i} <= '0;
        {op0_sid_i, op1_sid_i, wb0_sid_i, wb1_sid_i, wb_redirect_sid_i} <= '0;
        dec0_unit_i <= scb_unit_pkg::EXE_ALU;
        dec1_unit_i <= scb_unit_pkg::EXE_ALU;
    endtask

    task automatic drive_dec(input logic v0, input scb_unit_pkg::exe_unit_e u0, input int rd0,
                             input logic v1, input scb_unit_pkg::exe_unit_e u1, input int rd1);
        dec0_vld_i <= v0;
        dec0_unit_i <= u0;
        dec0_rd_i <= rd0;
        dec1_vld_i <= v1;
        dec1_unit_i <= u1;
        dec1_rd_i <= rd1;
    endtask

    // write back one busy slot per cycle until the table is empty
    task automatic release_all();
        int n;
        for (n = 0; n < 40 && sh_busy != '0; n++) begin
            tick();
            idle();
            for (int i = scb_unit_pkg::NUM_SLOTS - 1; i >= 0; i--) begin
                if (sh_busy[i]) begin
                    wb0_vld_i <= 1'b1;
                    wb0_sid_i <= sh_sid[i];
                end
            end
        end
        tick();
        idle();
        if (sh_busy != '0) begin
            errors++;
            $display("timeout: slot table did not drain through writeback");
        end
    endtask

    task automatic rand_cycle();
        int a;
        int b;
        tick();
        idle();
        drive_dec($urandom % 4 != 0, scb_unit_pkg::exe_unit_e'($urandom % 3), $urandom % 8,
                  $urandom % 4 != 0, scb_unit_pkg::exe_unit_e'($urandom % 3), $urandom % 8);
        op0_vld_i <= $urandom % 2;
        op0_sid_i <= sh_cnt - ($urandom % 6);
        op0_rd_i <= $urandom % 8;
        op0_rs1_i <= $urandom % 8;
        op0_rs2_i <= $urandom % 8;
        op1_vld_i <= $urandom % 2;
        op1_sid_i <= sh_cnt - ($urandom % 6);
        op1_rd_i <= $urandom % 8;
        op1_rs1_i <= $urandom % 8;
        op1_rs2_i <= $urandom % 8;
        a = $urandom % 4;
        b = $urandom % 4;
        if (sh_busy[a] && $urandom % 2) begin
            wb0_vld_i <= 1'b1;
            wb0_sid_i <= sh_sid[a];
        end
        if (sh_busy[b] && $urandom % 3 == 0) begin
            wb1_vld_i <= 1'b1;
            wb1_sid_i <= sh_sid[b];
        end
        if ($urandom % 16 == 0) begin
            wb_redirect_i <= 1'b1;
            wb_redirect_sid_i <= sh_cnt - ($urandom % 8);
        end
    endtask

    initial begin
        logic got;
        void'($urandom(32'h490e02ec));
        rst_n <= 1'b0;
        idle();
        repeat (4) tick();
        rst_n <= 1'b1;
        repeat (3) tick();

        // alu pair, then a third alu waits for writeback
        drive_dec(1'b1, scb_unit_pkg::EXE_ALU, 1, 1'b1, scb_unit_pkg::EXE_ALU, 2);
        tick();
        idle();
        drive_dec(1'b1, scb_unit_pkg::EXE_ALU, 3, 1'b0, scb_unit_pkg::EXE_ALU, 0);
        got = 1'b0;
        for (int n = 0; n < 20 && !got; n++) begin
            @(negedge clk);
            got = !dec0_stall_o;
            tick();
            wb0_vld_i <= (n == 1);
            wb0_sid_i <= sh_sid[scb_unit_pkg::SLOT_ALU0];
        end
        if (!got) begin
            errors++;
            $display("timeout: third alu instruction was never accepted");
        end
        idle();
        release_all();

        // write-after-write against a slot and within the pair
        drive_dec(1'b1, scb_unit_pkg::EXE_ALU, 5, 1'b0, scb_unit_pkg::EXE_ALU, 0);
        tick();
        drive_dec(1'b1, scb_unit_pkg::EXE_LSU, 5, 1'b1, scb_unit_pkg::EXE_BEU, 4);
        tick();
        drive_dec(1'b1, scb_unit_pkg::EXE_LSU, 6, 1'b1, scb_unit_pkg::EXE_BEU, 6);
        tick();
        idle();

        // read-after-write against the slots and within the pair
        op0_vld_i <= 1'b1;
        op0_sid_i <= sh_cnt;
        op0_rs1_i <= 5;
        op0_rd_i <= 9;
        op1_vld_i <= 1'b1;
        op1_sid_i <= sh_cnt - 3;
        op1_rs2_i <= 5;
        tick();
        // only the pair links the two now
        op0_rs1_i <= 0;
        op1_sid_i <= sh_cnt + 1;
        op1_rs1_i <= 9;
        op1_rs2_i <= 0;
        tick();
        idle();

        // redirect at the oldest busy slot kills the younger ones
        drive_dec(1'b1, scb_unit_pkg::EXE_ALU, 10, 1'b1, scb_unit_pkg::EXE_ALU, 11);
        tick();
        idle();
        wb_redirect_i <= 1'b1;
        wb_redirect_sid_i <= sh_sid[scb_unit_pkg::SLOT_ALU0];
        drive_dec(1'b1, scb_unit_pkg::EXE_BEU, 12, 1'b1, scb_unit_pkg::EXE_BEU, 13);
        op0_vld_i <= 1'b1;
        op0_sid_i <= sh_cnt;
        tick();
        idle();
        drive_dec(1'b1, scb_unit_pkg::EXE_ALU, 14, 1'b0, scb_unit_pkg::EXE_ALU, 0);
        tick();
        idle();
        release_all();

        repeat (600) rand_cycle();
        tick();
        idle();
        repeat (2) tick();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: common/scb_sid_pkg.sv
package scb_sid_pkg;

    localparam int SID_IDX_WIDTH  = 3;
    localparam int REG_ADDR_WIDTH = 5;

    // index bits plus a wrap bit on top
    typedef logic [SID_IDX_WIDTH:0]    sid_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    // true when a was issued after b
    function automatic logic sid_younger(
        input sid_t a,
        input sid_t b
    );
        if (a[SID_IDX_WIDTH] == b[SID_IDX_WIDTH]) begin
            return a[SID_IDX_WIDTH-1:0] > b[SID_IDX_WIDTH-1:0];
        end
        // counter wrapped between the two
        return a[SID_IDX_WIDTH-1:0] < b[SID_IDX_WIDTH-1:0];
    endfunction

endpackage

// File: common/scb_unit_pkg.sv
package scb_unit_pkg;

    localparam int NUM_SLOTS = 4;

    typedef enum logic [1:0] {
        EXE_ALU,
        EXE_BEU,
        EXE_LSU
    } exe_unit_e;

    typedef enum logic [1:0] {
        SLOT_ALU0,
        SLOT_ALU1,
        SLOT_BEU,
        SLOT_LSU
    } slot_e;

    // one bit per slot, indexed by slot_e
    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

endpackage

// File: issue/scb_issue.sv
`timescale 1ns/1ps

module scb_issue (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  logic                                                  dec0_vld_i,
    input  scb_unit_pkg::exe_unit_e                               dec0_unit_i,
    input  scb_sid_pkg::reg_addr_t                                dec0_rd_i,
    input  logic                                                  dec1_vld_i,
    input  scb_unit_pkg::exe_unit_e                               dec1_unit_i,
    input  scb_sid_pkg::reg_addr_t                                dec1_rd_i,
    input  scb_unit_pkg::slot_mask_t                              slot_busy_i,
    input  scb_sid_pkg::reg_addr_t [scb_unit_pkg::NUM_SLOTS-1:0]  slot_rd_i,
    output logic                                                  dec0_stall_o,
    output logic                                                  dec1_stall_o,
    output scb_sid_pkg::sid_t                                     dec0_sid_o,
    output scb_sid_pkg::sid_t                                     dec1_sid_o,
    output scb_unit_pkg::slot_mask_t                              dec0_slot_o,
    output scb_unit_pkg::slot_mask_t                              dec1_slot_o,
    output scb_unit_pkg::slot_mask_t                              wr0_mask_o,
    output scb_unit_pkg::slot_mask_t                              wr1_mask_o
);

    scb_unit_pkg::slot_mask_t pick0;
    scb_unit_pkg::slot_mask_t pick1;
    logic                     waw0;
    logic                     waw1;
    logic                     pair_waw;
    logic                     dec0_ok;
    logic                     dec1_ok;
    scb_sid_pkg::sid_t        sid_q;
    scb_sid_pkg::sid_t        sid_adv;

    // free unit for one instruction, alu0 before alu1
    function automatic scb_unit_pkg::slot_mask_t pick_slot(
        input scb_unit_pkg::exe_unit_e  unit,
        input scb_unit_pkg::slot_mask_t busy
    );
        scb_unit_pkg::slot_mask_t pick;
        pick = '0;
        case (unit)
            scb_unit_pkg::EXE_ALU: begin
                if (!busy[scb_unit_pkg::SLOT_ALU0]) begin
                    pick[scb_unit_pkg::SLOT_ALU0] = 1'b1;
                end else if (!busy[scb_unit_pkg::SLOT_ALU1]) begin
                    pick[scb_unit_pkg::SLOT_ALU1] = 1'b1;
                end
            end
            scb_unit_pkg::EXE_BEU: begin
                pick[scb_unit_pkg::SLOT_BEU] = !busy[scb_unit_pkg::SLOT_BEU];
            end
            scb_unit_pkg::EXE_LSU: begin
                pick[scb_unit_pkg::SLOT_LSU] = !busy[scb_unit_pkg::SLOT_LSU];
            end
            default: begin
                pick = '0;
            end
        endcase
        return pick;
    endfunction

    // write-after-write against every busy slot
    always_comb begin
        waw0 = 1'b0;
        waw1 = 1'b0;
        for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
            waw0 |= slot_busy_i[i] && (slot_rd_i[i] == dec0_rd_i);
            waw1 |= slot_busy_i[i] && (slot_rd_i[i] == dec1_rd_i);
        end
    end

    assign pick0   = pick_slot(dec0_unit_i, slot_busy_i);
    assign dec0_ok = dec0_vld_i && (|pick0) && !waw0;

    // second one sees the first one's slot as taken
    assign pick1    = pick_slot(dec1_unit_i, slot_busy_i | wr0_mask_o);
    assign pair_waw = dec0_vld_i && (dec0_rd_i == dec1_rd_i);
    assign dec1_ok  = dec1_vld_i && (|pick1) && !waw1 && !pair_waw && !dec0_stall_o;

    assign wr0_mask_o = dec0_ok ? pick0 : '0;
    assign wr1_mask_o = dec1_ok ? pick1 : '0;

    assign dec0_slot_o = wr0_mask_o;
    assign dec1_slot_o = wr1_mask_o;

    assign dec0_stall_o = dec0_vld_i && !dec0_ok;
    assign dec1_stall_o = dec1_vld_i && !dec1_ok;

    assign dec0_sid_o = sid_q;
    assign dec1_sid_o = sid_q + scb_sid_pkg::sid_t'(1);

    // advance by the number of accepted instructions
    assign sid_adv = scb_sid_pkg::sid_t'(dec0_ok) + scb_sid_pkg::sid_t'(dec1_ok);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_q <= '0;
        end else begin
            sid_q <= sid_q + sid_adv;
        end
    end

    a_wr_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (wr0_mask_o & wr1_mask_o) == '0);

endmodule

// File: scoreboard_top.f
common/scb_sid_pkg.sv
common/scb_unit_pkg.sv
issue/scb_issue.sv
source/scb_slot_table.sv
source/scb_raw_check.sv
source/scb_redirect_flush.sv
source/scoreboard_top.sv
bench/scoreboard_tb.sv

// File: source/scb_raw_check.sv
`timescale 1ns/1ps

module scb_raw_check (
    input  logic                                                  op0_vld_i,
    input  scb_sid_pkg::sid_t                                     op0_sid_i,
    input  scb_sid_pkg::reg_addr_t                                op0_rd_i,
    input  scb_sid_pkg::reg_addr_t                                op0_rs1_i,
    input  scb_sid_pkg::reg_addr_t                                op0_rs2_i,
    input  logic                                                  op1_vld_i,
    input  scb_sid_pkg::sid_t                                     op1_sid_i,
    input  scb_sid_pkg::reg_addr_t                                op1_rd_i,
    input  scb_sid_pkg::reg_addr_t                                op1_rs1_i,
    input  scb_sid_pkg::reg_addr_t                                op1_rs2_i,
    input  scb_unit_pkg::slot_mask_t                              slot_busy_i,
    input  scb_sid_pkg::reg_addr_t [scb_unit_pkg::NUM_SLOTS-1:0]  slot_rd_i,
    input  scb_sid_pkg::sid_t [scb_unit_pkg::NUM_SLOTS-1:0]       slot_sid_i,
    output logic                                                  op0_stall_o,
    output logic                                                  op1_stall_o
);

    logic pair0;
    logic pair1;

    // any older busy slot still to write one of our sources
    function automatic logic slot_raw(
        input scb_sid_pkg::sid_t      sid,
        input scb_sid_pkg::reg_addr_t rs1,
        input scb_sid_pkg::reg_addr_t rs2
    );
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
            if (slot_busy_i[i] && (slot_rd_i[i] == rs1 || slot_rd_i[i] == rs2) &&
                scb_sid_pkg::sid_younger(sid, slot_sid_i[i])) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // within the pair only the older one can block
    assign pair0 = op1_vld_i && (op1_rd_i == op0_rs1_i || op1_rd_i == op0_rs2_i) &&
                   scb_sid_pkg::sid_younger(op0_sid_i, op1_sid_i);
    assign pair1 = op0_vld_i && (op0_rd_i == op1_rs1_i || op0_rd_i == op1_rs2_i) &&
                   scb_sid_pkg::sid_younger(op1_sid_i, op0_sid_i);

    always_comb begin
        op0_stall_o = op0_vld_i && (slot_raw(op0_sid_i, op0_rs1_i, op0_rs2_i) || pair0);
        op1_stall_o = op1_vld_i && (slot_raw(op1_sid_i, op1_rs1_i, op1_rs2_i) || pair1);
    end

endmodule

// File: source/scb_redirect_flush.sv
`timescale 1ns/1ps

module scb_redirect_flush (
    input  logic                                             wb_redirect_i,
    input  scb_sid_pkg::sid_t                                wb_redirect_sid_i,
    input  logic                                             dec0_vld_i,
    input  logic                                             dec1_vld_i,
    input  scb_sid_pkg::sid_t                                dec0_sid_i,
    input  scb_sid_pkg::sid_t                                dec1_sid_i,
    input  logic                                             op0_vld_i,
    input  logic                                             op1_vld_i,
    input  scb_sid_pkg::sid_t                                op0_sid_i,
    input  scb_sid_pkg::sid_t                                op1_sid_i,
    input  scb_unit_pkg::slot_mask_t                         slot_busy_i,
    input  scb_sid_pkg::sid_t [scb_unit_pkg::NUM_SLOTS-1:0]  slot_sid_i,
    output logic                                             dec0_flush_o,
    output logic                                             dec1_flush_o,
    output logic                                             op0_flush_o,
    output logic                                             op1_flush_o,
    output scb_unit_pkg::slot_mask_t                         slot_kill_o
);

    // the one age rule for everything behind the redirect
    function automatic logic flush_hit(
        input logic              vld,
        input scb_sid_pkg::sid_t sid
    );
        return wb_redirect_i && vld && scb_sid_pkg::sid_younger(sid, wb_redirect_sid_i);
    endfunction

    always_comb begin
        dec0_flush_o = flush_hit(dec0_vld_i, dec0_sid_i);
        dec1_flush_o = flush_hit(dec1_vld_i, dec1_sid_i);
        op0_flush_o  = flush_hit(op0_vld_i, op0_sid_i);
        op1_flush_o  = flush_hit(op1_vld_i, op1_sid_i);
        for (int i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin
            slot_kill_o[i] = flush_hit(slot_busy_i[i], slot_sid_i[i]);
        end
    end

endmodule

// File: source/scb_slot_table.sv
`timescale 1ns/1ps

module scb_slot_table (
    input  logic                                                  clk,
    input  logic                                                  rst_n,
    input  scb_unit_pkg::slot_mask_t                              wr0_mask_i,
    input  scb_unit_pkg::slot_mask_t                              wr1_mask_i,
    input  scb_sid_pkg::sid_t                                     dec0_sid_i,
    input  scb_sid_pkg::sid_t                                     dec1_sid_i,
    input  scb_sid_pkg::reg_addr_t                                dec0_rd_i,
    input  scb_sid_pkg::reg_addr_t                                dec0_rs1_i,
    input  scb_sid_pkg::reg_addr_t                                dec0_rs2_i,
    input  scb_sid_pkg::reg_addr_t                                dec1_rd_i,
    input  scb_sid_pkg::reg_addr_t                                dec1_rs1_i,
    input  scb_sid_pkg::reg_addr_t                                dec1_rs2_i,
    input  logic                                                  wb0_vld_i,
    input  scb_sid_pkg::sid_t                                     wb0_sid_i,
    input  logic                                                  wb1_vld_i,
    input  scb_sid_pkg::sid_t                                     wb1_sid_i,
    input  scb_unit_pkg::slot_mask_t                              slot_kill_i,
    output scb_unit_pkg::slot_mask_t                              slot_busy_o,
    output scb_sid_pkg::reg_addr_t [scb_unit_pkg::NUM_SLOTS-1:0]  slot_rd_o,
    output scb_sid_pkg::sid_t [scb_unit_pkg::NUM_SLOTS-1:0]       slot_sid_o
);

    scb_unit_pkg::slot_mask_t rel0;
    scb_unit_pkg::slot_mask_t rel1;

    for (genvar i = 0; i < scb_unit_pkg::NUM_SLOTS; i++) begin : g_slot
        logic                   busy_q;
        logic                   wr;
        scb_sid_pkg::sid_t      sid_q;
        scb_sid_pkg::reg_addr_t rd_q;
        // sources kept for a later write-after-read check
        scb_sid_pkg::reg_addr_t rs1_q;
        scb_sid_pkg::reg_addr_t rs2_q;

        assign wr      = wr0_mask_i[i] || wr1_mask_i[i];
        assign rel0[i] = wb0_vld_i && (wb0_sid_i == sid_q);
        assign rel1[i] = wb1_vld_i && (wb1_sid_i == sid_q);

        // kill, then write, then release
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                busy_q <= 1'b0;
            end else if (slot_kill_i[i]) begin
                busy_q <= 1'b0;
            end else if (wr) begin
                busy_q <= 1'b1;
            end else if (rel0[i] || rel1[i]) begin
                busy_q <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (wr0_mask_i[i]) begin
                sid_q <= dec0_sid_i;
                rd_q  <= dec0_rd_i;
                rs1_q <= dec0_rs1_i;
                rs2_q <= dec0_rs2_i;
            end else if (wr1_mask_i[i]) begin
                sid_q <= dec1_sid_i;
                rd_q  <= dec1_rd_i;
                rs1_q <= dec1_rs1_i;
                rs2_q <= dec1_rs2_i;
            end
        end

        assign slot_busy_o[i] = busy_q;
        assign slot_rd_o[i]   = rd_q;
        assign slot_sid_o[i]  = sid_q;
    end

    // issue only ever fills free slots
    a_wr_free: assert property (@(posedge clk) disable iff (!rst_n)
        ((wr0_mask_i | wr1_mask_i) & slot_busy_o) == '0);

    // writeback must name an instruction still in flight
    a_wb0_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wb0_vld_i |-> |(rel0 & slot_busy_o));
    a_wb1_busy: assert property (@(posedge clk) disable iff (!rst_n)
        wb1_vld_i |-> |(rel1 & slot_busy_o));

endmodule

// File: source/scoreboard_top.sv
`timescale 1ns/1ps

module scoreboard_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dec0_vld_i,
    input  scb_unit_pkg::exe_unit_e  dec0_unit_i,
    input  scb_sid_pkg::reg_addr_t   dec0_rd_i,
    input  scb_sid_pkg::reg_addr_t   dec0_rs1_i,
    input  scb_sid_pkg::reg_addr_t   dec0_rs2_i,
    input  logic                     dec1_vld_i,
    input  scb_unit_pkg::exe_unit_e  dec1_unit_i,
    input  scb_sid_pkg::reg_addr_t   dec1_rd_i,
    input  scb_sid_pkg::reg_addr_t   dec1_rs1_i,
    input  scb_sid_pkg::reg_addr_t   dec1_rs2_i,
    output logic                     dec0_stall_o,
    output logic                     dec1_stall_o,
    output logic                     dec0_flush_o,
    output logic                     dec1_flush_o,
    output scb_sid_pkg::sid_t        dec0_sid_o,
    output scb_sid_pkg::sid_t        dec1_sid_o,
    output scb_unit_pkg::slot_mask_t dec0_slot_o,
    output scb_unit_pkg::slot_mask_t dec1_slot_o,
    input  logic                     op0_vld_i,
    input  scb_sid_pkg::sid_t        op0_sid_i,
    input  scb_sid_pkg::reg_addr_t   op0_rd_i,
    input  scb_sid_pkg::reg_addr_t   op0_rs1_i,
    input  scb_sid_pkg::reg_addr_t   op0_rs2_i,
    input  logic                     op1_vld_i,
    input  scb_sid_pkg::sid_t        op1_sid_i,
    input  scb_sid_pkg::reg_addr_t   op1_rd_i,
    input  scb_sid_pkg::reg_addr_t   op1_rs1_i,
    input  scb_sid_pkg::reg_addr_t   op1_rs2_i,
    output logic                     op0_stall_o,
    output logic                     op1_stall_o,
    output logic                     op0_flush_o,
    output logic                     op1_flush_o,
    input  logic                     wb0_vld_i,
    input  scb_sid_pkg::sid_t        wb0_sid_i,
    input  logic                     wb1_vld_i,
    input  scb_sid_pkg::sid_t        wb1_sid_i,
    input  logic                     wb_redirect_i,
    input  scb_sid_pkg::sid_t        wb_redirect_sid_i
);

    scb_unit_pkg::slot_mask_t                              wr0_mask;
    scb_unit_pkg::slot_mask_t                              wr1_mask;
    scb_unit_pkg::slot_mask_t                              slot_busy;
    scb_unit_pkg::slot_mask_t                              slot_kill;
    scb_sid_pkg::reg_addr_t [scb_unit_pkg::NUM_SLOTS-1:0]  slot_rd;
    scb_sid_pkg::sid_t [scb_unit_pkg::NUM_SLOTS-1:0]       slot_sid;

    scb_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec0_vld_i   (dec0_vld_i),
        .dec0_unit_i  (dec0_unit_i),
        .dec0_rd_i    (dec0_rd_i),
        .dec1_vld_i   (dec1_vld_i),
        .dec1_unit_i  (dec1_unit_i),
        .dec1_rd_i    (dec1_rd_i),
        .slot_busy_i  (slot_busy),
        .slot_rd_i    (slot_rd),
        .dec0_stall_o (dec0_stall_o),
        .dec1_stall_o (dec1_stall_o),
        .dec0_sid_o   (dec0_sid_o),
        .dec1_sid_o   (dec1_sid_o),
        .dec0_slot_o  (dec0_slot_o),
        .dec1_slot_o  (dec1_slot_o),
        .wr0_mask_o   (wr0_mask),
        .wr1_mask_o   (wr1_mask)
    );

    scb_slot_table u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr0_mask_i  (wr0_mask),
        .wr1_mask_i  (wr1_mask),
        .dec0_sid_i  (dec0_sid_o),
        .dec1_sid_i  (dec1_sid_o),
        .dec0_rd_i   (dec0_rd_i),
        .dec0_rs1_i  (dec0_rs1_i),
        .dec0_rs2_i  (dec0_rs2_i),
        .dec1_rd_i   (dec1_rd_i),
        .dec1_rs1_i  (dec1_rs1_i),
        .dec1_rs2_i  (dec1_rs2_i),
        .wb0_vld_i   (wb0_vld_i),
        .wb0_sid_i   (wb0_sid_i),
        .wb1_vld_i   (wb1_vld_i),
        .wb1_sid_i   (wb1_sid_i),
        .slot_kill_i (slot_kill),
        .slot_busy_o (slot_busy),
        .slot_rd_o   (slot_rd),
        .slot_sid_o  (slot_sid)
    );

    scb_raw_check u_raw (
        .op0_vld_i   (op0_vld_i),
        .op0_sid_i   (op0_sid_i),
        .op0_rd_i    (op0_rd_i),
        .op0_rs1_i   (op0_rs1_i),
        .op0_rs2_i   (op0_rs2_i),
        .op1_vld_i   (op1_vld_i),
        .op1_sid_i   (op1_sid_i),
        .op1_rd_i    (op1_rd_i),
        .op1_rs1_i   (op1_rs1_i),
        .op1_rs2_i   (op1_rs2_i),
        .slot_busy_i (slot_busy),
        .slot_rd_i   (slot_rd),
        .slot_sid_i  (slot_sid),
        .op0_stall_o (op0_stall_o),
        .op1_stall_o (op1_stall_o)
    );

    scb_redirect_flush u_flush (
        .wb_redirect_i     (wb_redirect_i),
        .wb_redirect_sid_i (wb_redirect_sid_i),
        .dec0_vld_i        (dec0_vld_i),
        .dec1_vld_i        (dec1_vld_i),
        .dec0_sid_i        (dec0_sid_o),
        .dec1_sid_i        (dec1_sid_o),
        .op0_vld_i         (op0_vld_i),
        .op1_vld_i         (op1_vld_i),
        .op0_sid_i         (op0_sid_i),
        .op1_sid_i         (op1_sid_i),
        .slot_busy_i       (slot_busy),
        .slot_sid_i        (slot_sid),
        .dec0_flush_o      (dec0_flush_o),
        .dec1_flush_o      (dec1_flush_o),
        .op0_flush_o       (op0_flush_o),
        .op1_flush_o       (op1_flush_o),
        .slot_kill_o       (slot_kill)
    );

endmodule
